//--- files.f
hdl/mcs51_pkg.sv
hdl/mcs51_alu.sv
hdl/mcs51_decoder.sv
hdl/mcs51_data_space.sv
hdl/mcs51_fetch_ctrl.sv
hdl/mcs51_top.sv
verification/mcs51_checker.sv
verification/tb_mcs51.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mcs51
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_mcs51.sv
// Testbench for the 8051 subset core with a random program and wait-stated program memory
`default_nettype none

module tb_mcs51;
	import mcs51_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_INSTR    = 60;
	// Five cycles per instruction, four times that for wait states, plus margin
	localparam int WATCHDOG_TIME = NUM_INSTR * 5 * 4 * CLK_PERIOD + 100 * CLK_PERIOD;

	logic        clk;
	logic        sys_rst_n;
	addr_t       mem_addr;
	byte_t       mem_rdata;
	logic        psen_n;
	logic        ready;
	byte_t       p1;
	logic        run_done;
	int          check_count;
	int          error_count;

	byte_t       prog_mem [256];
	byte_t       gen_addr;
	int unsigned lcg_state;

	// Program memory answers from the address currently on the bus
	assign mem_rdata = prog_mem[mem_addr[7:0]];

	mcs51_top u_mcs51_top (
		.clk         (clk),
		.sys_rst_n   (sys_rst_n),
		.mem_addr_o  (mem_addr),
		.mem_rdata_i (mem_rdata),
		.psen_n_o    (psen_n),
		.ready_i     (ready),
		.p1_o        (p1)
	);

	mcs51_checker u_mcs51_checker (
		.clk           (clk),
		.sys_rst_n     (sys_rst_n),
		.mem_addr_i    (mem_addr),
		.mem_rdata_i   (mem_rdata),
		.psen_n_i      (psen_n),
		.ready_i       (ready),
		.p1_i          (p1),
		.done_o        (run_done),
		.check_count_o (check_count),
		.error_count_o (error_count)
	);

	// ----------------------------------------------------------------------
	// Random program generation
	// ----------------------------------------------------------------------
	function automatic int unsigned next_rand(input int unsigned bound);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % bound;
	endfunction

	function automatic byte_t pick_direct();
		int unsigned r;
		r = next_rand(19);
		if (r < 16)
			return 8'h30 + 8'(r);
		else if (r == 16)
			return SFR_P1;
		else if (r == 17)
			return SFR_ACC;
		return SFR_PSW;
	endfunction

	task automatic emit_byte(input byte_t value);
		prog_mem[gen_addr] = value;
		gen_addr = gen_addr + 8'd1;
	endtask

	task automatic emit_pair(input byte_t op, input byte_t arg);
		emit_byte(op);
		emit_byte(arg);
	endtask

	// One-byte instructions, also used to pad over jump offsets
	task automatic emit_short();
		byte_t reg_n;
		reg_n = 8'(next_rand(8));
		case (next_rand(9))
			0:       emit_byte(OP_NOP);
			1:       emit_byte(OP_CPL_A);
			2:       emit_byte(OP_RL_A);
			3:       emit_byte(OP_RR_A);
			4:       emit_byte(OP_SWAP_A);
			5:       emit_byte({OPH_MOV_A_RN, reg_n[2:0]});
			6:       emit_byte({OPH_MOV_RN_A, reg_n[2:0]});
			7:       emit_byte({OPH_ADD_RN, reg_n[2:0]});
			default: emit_byte({OPH_ADDC_RN, reg_n[2:0]});
		endcase
	endtask

	task automatic build_program();
		int          count;
		int unsigned kind;
		byte_t       offset;
		lcg_state = 20;
		gen_addr  = 8'h00;
		count     = 0;
		for (int i = 0; i < 256; i++)
			prog_mem[i[7:0]] = i[7:0] ^ 8'h5A;
		while (count < NUM_INSTR)
		begin
			count++;
			kind = next_rand(16);
			case (kind)
				0, 1, 2, 3: emit_short();
				4:          emit_pair(OP_MOV_A_IMM, 8'(next_rand(256)));
				5:          emit_pair(OP_MOV_A_DIR, pick_direct());
				6:          emit_pair(OP_MOV_DIR_A, pick_direct());
				7:          emit_pair(OP_MOV_DIR_A, SFR_P1);
				8:          emit_pair(OP_ADD_IMM, 8'(next_rand(256)));
				9:          emit_pair(OP_ADDC_IMM, 8'(next_rand(256)));
				10:         emit_pair(OP_ANL_IMM, 8'(next_rand(256)));
				11:         emit_pair(OP_ORL_IMM, 8'(next_rand(256)));
				12:         emit_pair(OP_XRL_IMM, 8'(next_rand(256)));
				default:
				begin
					offset = 8'(next_rand(7));
					if (kind == 13)
						emit_pair(OP_SJMP, offset);
					else if (kind == 14)
						emit_pair(OP_JZ, offset);
					else
						emit_pair(OP_JNZ, offset);
					// Skipped bytes are single-byte instructions so targets stay aligned
					for (int k = 0; k < int'(offset); k++)
					begin
						emit_short();
						count++;
					end
				end
			endcase
		end
		// Final loop on itself
		emit_pair(OP_SJMP, 8'hFE);
	endtask

	// ----------------------------------------------------------------------
	// Clock, reset, wait states and run control
	// ----------------------------------------------------------------------
	initial
	begin : clock_gen
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin : stimulus
		sys_rst_n = 1'b0;
		ready     = 1'b0;
		build_program();
		repeat (RESET_CYCLES)
			@(posedge clk);
		sys_rst_n <= 1'b1;
		// Roughly one cycle in three without ready
		forever
		begin
			@(posedge clk);
			ready <= (next_rand(3) != 32'd0);
		end
	end

	initial
	begin : end_of_run
		wait (run_done === 1'b1);
		$display("tests 5, checks %0d, failures %0d", check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_TIME);
		$display("Timeout, the program did not reach its final loop within %0d time units",
			WATCHDOG_TIME);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/mcs51_checker.sv
// Instruction-set model of the 8051 subset that checks fetch addresses and P1 against the core
`default_nettype none

module mcs51_checker (
	input  logic             clk,
	input  logic             sys_rst_n,
	input  mcs51_pkg::addr_t mem_addr_i,
	input  mcs51_pkg::byte_t mem_rdata_i,
	input  logic             psen_n_i,
	input  logic             ready_i,
	input  mcs51_pkg::byte_t p1_i,
	output logic             done_o,
	output int               check_count_o,
	output int               error_count_o
);
	import mcs51_pkg::*;

	localparam logic [2:0] T_RESET  = 3'd0;
	localparam logic [2:0] T_FETCH  = 3'd1;
	localparam logic [2:0] T_BRANCH = 3'd2;
	localparam logic [2:0] T_P1     = 3'd3;
	localparam logic [2:0] T_END    = 3'd4;

	// Architectural state of the model
	byte_t m_acc;
	byte_t m_psw;
	byte_t m_p1;
	byte_t m_iram [IRAM_DEPTH];
	addr_t m_pc;

	// Sequencing and bookkeeping
	byte_t m_opcode;
	logic  want_operand;
	logic  after_branch;
	logic  at_end;
	logic  first_fetch;
	addr_t end_addr;
	byte_t p1_seen;
	byte_t p1_queue [$];
	logic  finished = 1'b0;
	int    total_checks = 0;
	int    total_fails = 0;
	int    test_checks [8] = '{default: 0};
	int    test_fails [8] = '{default: 0};

	assign done_o        = finished;
	assign check_count_o = total_checks;
	assign error_count_o = total_fails;

	function automatic string test_name(input logic [2:0] t);
		case (t)
			T_RESET:  return "reset";
			T_FETCH:  return "fetch_sequence";
			T_BRANCH: return "branch";
			T_P1:     return "p1_value";
			default:  return "end_of_program";
		endcase
	endfunction

	task automatic check_value(input logic [2:0] t, input logic [15:0] expected,
		input logic [15:0] actual);
		test_checks[t]++;
		total_checks++;
		if (actual !== expected)
		begin
			test_fails[t]++;
			total_fails++;
			$display("FAIL %s expected 0x%0h actual 0x%0h", test_name(t), expected, actual);
		end
	endtask

	task automatic report_problem(input logic [2:0] t, input string text);
		test_checks[t]++;
		test_fails[t]++;
		total_checks++;
		total_fails++;
		$display("FAIL %s %s", test_name(t), text);
	endtask

	task automatic report_test(input logic [2:0] t);
		$display("test %s finished: %0d checks, %0d failed", test_name(t), test_checks[t],
			test_fails[t]);
	endtask

	// ----------------------------------------------------------------------
	// Instruction-set model
	// ----------------------------------------------------------------------
	function automatic logic two_byte(input byte_t op);
		case (op)
			OP_MOV_A_IMM, OP_MOV_A_DIR, OP_MOV_DIR_A, OP_ADD_IMM, OP_ADDC_IMM,
			OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM, OP_SJMP, OP_JZ, OP_JNZ:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Bank select from RS1:RS0
	function automatic logic [6:0] reg_addr(input logic [2:0] n);
		return {2'b00, m_psw[4:3], n};
	endfunction

	function automatic byte_t read_dir(input byte_t a);
		if (!a[7])
			return m_iram[a[6:0]];
		case (a)
			SFR_ACC: return m_acc;
			SFR_PSW: return {m_psw[7:1], ^m_acc};
			SFR_P1:  return m_p1;
			default: return 8'h00;
		endcase
	endfunction

	task automatic write_dir(input byte_t a, input byte_t v);
		if (!a[7])
			m_iram[a[6:0]] = v;
		else if (a == SFR_ACC)
			m_acc = v;
		else if (a == SFR_PSW)
			m_psw = v;
		else if (a == SFR_P1)
		begin
			// Only a new value shows up as a change on the port
			if (v != m_p1)
				p1_queue.push_back(v);
			m_p1 = v;
		end
	endtask

	task automatic add_to_acc(input byte_t b, input logic use_carry);
		logic       cin;
		logic [8:0] full;
		logic [4:0] low;
		logic [7:0] low7;
		cin  = use_carry & m_psw[7];
		full = {1'b0, m_acc} + {1'b0, b} + {8'h00, cin};
		low  = {1'b0, m_acc[3:0]} + {1'b0, b[3:0]} + {4'h0, cin};
		low7 = {1'b0, m_acc[6:0]} + {1'b0, b[6:0]} + {7'h00, cin};
		m_psw[7] = full[8];
		m_psw[6] = low[4];
		// Carry into bit 7 against carry out of it
		m_psw[2] = full[8] ^ low7[7];
		m_acc    = full[7:0];
	endtask

	task automatic take_branch(input byte_t offset, input logic taken);
		addr_t target;
		after_branch = 1'b1;
		target = m_pc + {{8{offset[7]}}, offset};
		if (taken)
		begin
			if (target == m_pc - 16'd2)
			begin
				at_end   = 1'b1;
				end_addr = target;
			end
			m_pc = target;
		end
	endtask

	task automatic execute(input byte_t op, input byte_t arg);
		after_branch = 1'b0;
		if (op[3])
		begin
			case (op[7:3])
				OPH_MOV_A_RN: m_acc = m_iram[reg_addr(op[2:0])];
				OPH_MOV_RN_A: m_iram[reg_addr(op[2:0])] = m_acc;
				OPH_ADD_RN:   add_to_acc(m_iram[reg_addr(op[2:0])], 1'b0);
				OPH_ADDC_RN:  add_to_acc(m_iram[reg_addr(op[2:0])], 1'b1);
				default:      m_acc = m_acc;
			endcase
		end
		else
		begin
			case (op)
				OP_MOV_A_IMM: m_acc = arg;
				OP_MOV_A_DIR: m_acc = read_dir(arg);
				OP_MOV_DIR_A: write_dir(arg, m_acc);
				OP_ADD_IMM:   add_to_acc(arg, 1'b0);
				OP_ADDC_IMM:  add_to_acc(arg, 1'b1);
				OP_ANL_IMM:   m_acc = m_acc & arg;
				OP_ORL_IMM:   m_acc = m_acc | arg;
				OP_XRL_IMM:   m_acc = m_acc ^ arg;
				OP_CPL_A:     m_acc = ~m_acc;
				OP_RL_A:      m_acc = {m_acc[6:0], m_acc[7]};
				OP_RR_A:      m_acc = {m_acc[0], m_acc[7:1]};
				OP_SWAP_A:    m_acc = {m_acc[3:0], m_acc[7:4]};
				OP_SJMP:      take_branch(arg, 1'b1);
				OP_JZ:        take_branch(arg, m_acc == 8'h00);
				OP_JNZ:       take_branch(arg, m_acc != 8'h00);
				default:      m_acc = m_acc;
			endcase
		end
	endtask

	// ----------------------------------------------------------------------
	// Bus monitor
	// ----------------------------------------------------------------------
	task automatic end_of_program();
		check_value(T_END, end_addr, mem_addr_i);
		if (p1_queue.size() != 0)
			report_problem(T_END, $sformatf("%0d expected P1 values never appeared on p1_o",
				p1_queue.size()));
		report_test(T_FETCH);
		report_test(T_BRANCH);
		report_test(T_P1);
		report_test(T_END);
		finished = 1'b1;
	endtask

	task automatic accept_byte();
		if (want_operand)
		begin
			check_value(T_FETCH, m_pc, mem_addr_i);
			m_pc = m_pc + 16'd1;
			want_operand = 1'b0;
			execute(m_opcode, mem_rdata_i);
		end
		else
		begin
			if (first_fetch)
			begin
				check_value(T_RESET, 16'h0000, mem_addr_i);
				check_value(T_RESET, 16'h0000, 16'(p1_i));
				first_fetch = 1'b0;
				report_test(T_RESET);
			end
			check_value(after_branch ? T_BRANCH : T_FETCH, m_pc, mem_addr_i);
			if (at_end)
				end_of_program();
			else
			begin
				m_opcode = mem_rdata_i;
				m_pc = m_pc + 16'd1;
				if (two_byte(m_opcode))
					want_operand = 1'b1;
				else
					execute(m_opcode, 8'h00);
			end
		end
	endtask

	always @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			m_acc        = 8'h00;
			m_psw        = 8'h00;
			m_p1         = 8'h00;
			m_pc         = 16'h0000;
			want_operand = 1'b0;
			after_branch = 1'b0;
			at_end       = 1'b0;
			first_fetch  = 1'b1;
			end_addr     = 16'h0000;
			p1_seen      = 8'h00;
			p1_queue.delete();
			for (int i = 0; i < IRAM_DEPTH; i++)
				m_iram[i[6:0]] = 8'h00;
		end
		else if (!finished)
		begin
			// P1 first, a write always lands before the next opcode is taken
			if (p1_i !== p1_seen)
			begin
				if (p1_queue.size() == 0)
					report_problem(T_P1, $sformatf(
						"p1_o changed to 0x%02h while the model had no P1 write pending", p1_i));
				else
					check_value(T_P1, 16'(p1_queue.pop_front()), 16'(p1_i));
				p1_seen = p1_i;
			end
			if (!psen_n_i && ready_i)
				accept_byte();
		end
	end

endmodule

`default_nettype wire

//--- hdl/mcs51_top.sv
// 8051 subset core top level joining fetch control, decoder, ALU and data space
`default_nettype none

module mcs51_top (
	input  logic             clk,
	input  logic             sys_rst_n,
	output mcs51_pkg::addr_t mem_addr_o,
	input  mcs51_pkg::byte_t mem_rdata_i,
	output logic             psen_n_o,
	input  logic             ready_i,
	output mcs51_pkg::byte_t p1_o
);
	import mcs51_pkg::*;

	byte_t   opcode;
	byte_t   operand;
	logic    has_operand;
	src_e    src_sel;
	dst_e    dst_sel;
	alu_op_e alu_op;
	branch_e branch_kind;
	logic [2:0] reg_idx;
	byte_t   acc;
	byte_t   src_val;
	logic    cy;
	byte_t   result;
	logic    alu_cy;
	logic    alu_ac;
	logic    alu_ov;
	logic    commit;

	mcs51_fetch_ctrl u_fetch_ctrl (
		.clk           (clk),
		.sys_rst_n     (sys_rst_n),
		.mem_addr_o    (mem_addr_o),
		.mem_rdata_i   (mem_rdata_i),
		.psen_n_o      (psen_n_o),
		.ready_i       (ready_i),
		.opcode_o      (opcode),
		.operand_o     (operand),
		.has_operand_i (has_operand),
		.branch_kind_i (branch_kind),
		.acc_i         (acc),
		.commit_o      (commit)
	);

	mcs51_decoder u_decoder (
		.clk           (clk),
		.sys_rst_n     (sys_rst_n),
		.opcode_i      (opcode),
		.has_operand_o (has_operand),
		.src_sel_o     (src_sel),
		.dst_sel_o     (dst_sel),
		.alu_op_o      (alu_op),
		.branch_kind_o (branch_kind),
		.reg_idx_o     (reg_idx)
	);

	mcs51_alu u_alu (
		.op_i     (alu_op),
		.a_i      (acc),
		.b_i      (src_val),
		.cy_i     (cy),
		.result_o (result),
		.cy_o     (alu_cy),
		.ac_o     (alu_ac),
		.ov_o     (alu_ov)
	);

	mcs51_data_space u_data_space (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.commit_i  (commit),
		.src_sel_i (src_sel),
		.dst_sel_i (dst_sel),
		.alu_op_i  (alu_op),
		.reg_idx_i (reg_idx),
		.operand_i (operand),
		.result_i  (result),
		.cy_i      (alu_cy),
		.ac_i      (alu_ac),
		.ov_i      (alu_ov),
		.acc_o     (acc),
		.src_val_o (src_val),
		.cy_o      (cy),
		.p1_o      (p1_o)
	);

endmodule

`default_nettype wire

//--- hdl/mcs51_fetch_ctrl.sv
// Phase sequencer with PC, instruction buffers and branch resolution for the core
`default_nettype none

module mcs51_fetch_ctrl (
	input  logic               clk,
	input  logic               sys_rst_n,
	output mcs51_pkg::addr_t   mem_addr_o,
	input  mcs51_pkg::byte_t   mem_rdata_i,
	output logic               psen_n_o,
	input  logic               ready_i,
	output mcs51_pkg::byte_t   opcode_o,
	output mcs51_pkg::byte_t   operand_o,
	input  logic               has_operand_i,
	input  mcs51_pkg::branch_e branch_kind_i,
	input  mcs51_pkg::byte_t   acc_i,
	output logic               commit_o
);
	import mcs51_pkg::*;

	phase_e phase_q;
	addr_t  pc_q;
	byte_t  opcode_q;
	byte_t  operand_q;
	logic   run_q;
	logic   take_q;
	logic   take_d;
	logic   fetching;
	logic   accept;
	addr_t  target;

	// Program memory handshake with one byte per accepted edge
	assign fetching   = run_q && (phase_q == PH_FETCH || phase_q == PH_OPERAND);
	assign accept     = fetching && ready_i;
	assign psen_n_o   = !fetching;
	assign mem_addr_o = pc_q;

	// Decoder sees the incoming byte while the opcode is on the bus
	assign opcode_o  = (phase_q == PH_FETCH) ? mem_rdata_i : opcode_q;
	assign operand_o = operand_q;
	assign commit_o  = (phase_q == PH_WRITE);

	// Relative target from the PC past the instruction
	assign target = pc_q + {{8{operand_q[7]}}, operand_q};

	always_comb
	begin
		case (branch_kind_i)
			BR_SJMP: take_d = 1'b1;
			BR_JZ:   take_d = (acc_i == 8'h00);
			BR_JNZ:  take_d = (acc_i != 8'h00);
			default: take_d = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------
	// Phase sequencer and program counter
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			phase_q <= PH_FETCH;
			pc_q    <= '0;
			run_q   <= 1'b0;
			take_q  <= 1'b0;
		end
		else
		begin
			run_q <= 1'b1;
			case (phase_q)
				PH_FETCH:
				begin
					if (accept)
					begin
						pc_q    <= pc_q + 16'd1;
						phase_q <= has_operand_i ? PH_OPERAND : PH_EXEC;
					end
				end
				PH_OPERAND:
				begin
					if (accept)
					begin
						pc_q    <= pc_q + 16'd1;
						phase_q <= PH_EXEC;
					end
				end
				PH_EXEC:
				begin
					take_q  <= take_d;
					phase_q <= PH_WRITE;
				end
				default:
				begin
					if (take_q)
						pc_q <= target;
					phase_q <= PH_FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && phase_q == PH_FETCH)
			opcode_q <= mem_rdata_i;
		if (accept && phase_q == PH_OPERAND)
			operand_q <= mem_rdata_i;
	end

	// ------------------------------------------------------------------
	// Handshake checks
	// ------------------------------------------------------------------
	// Stalled request keeps address and strobe until ready
	a_addr_hold : assert property (@(posedge clk) disable iff (!sys_rst_n)
		(!psen_n_o && !ready_i) |=> (!psen_n_o && $stable(mem_addr_o)));

	// Strobe rests through execute and write after the last byte, then fetch resumes
	a_exec_gap : assert property (@(posedge clk) disable iff (!sys_rst_n)
		$past(accept && (phase_q == PH_OPERAND || !has_operand_i), 3)
			|-> (!psen_n_o && $past(psen_n_o) && $past(psen_n_o, 2)));

endmodule

`default_nettype wire

//--- hdl/mcs51_data_space.sv
// Internal RAM, banked registers and ACC, PSW, P1 with direct address decoding
`default_nettype none

module mcs51_data_space (
	input  logic               clk,
	input  logic               sys_rst_n,
	input  logic               commit_i,
	input  mcs51_pkg::src_e    src_sel_i,
	input  mcs51_pkg::dst_e    dst_sel_i,
	input  mcs51_pkg::alu_op_e alu_op_i,
	input  logic [2:0]         reg_idx_i,
	input  mcs51_pkg::byte_t   operand_i,
	input  mcs51_pkg::byte_t   result_i,
	input  logic               cy_i,
	input  logic               ac_i,
	input  logic               ov_i,
	output mcs51_pkg::byte_t   acc_o,
	output mcs51_pkg::byte_t   src_val_o,
	output logic               cy_o,
	output mcs51_pkg::byte_t   p1_o
);
	import mcs51_pkg::*;

	byte_t      iram_q [IRAM_DEPTH];
	byte_t      acc_q;
	byte_t      psw_q;
	byte_t      p1_q;
	byte_t      psw_rd;
	byte_t      dir_rd;
	logic [6:0] reg_addr;

	// Rn lives at RS*8 + n
	assign reg_addr = {2'b00, psw_q[PSW_RS1], psw_q[PSW_RS0], reg_idx_i};

	assign acc_o = acc_q;
	assign cy_o  = psw_q[PSW_CY];
	assign p1_o  = p1_q;

	// Parity bit tracks ACC
	always_comb
	begin
		psw_rd        = psw_q;
		psw_rd[PSW_P] = ^acc_q;
	end

	// ------------------------------------------------------------------
	// Read side
	// ------------------------------------------------------------------
	always_comb
	begin
		if (!operand_i[7])
			dir_rd = iram_q[operand_i[6:0]];
		else
		begin
			case (operand_i)
				SFR_ACC: dir_rd = acc_q;
				SFR_PSW: dir_rd = psw_rd;
				SFR_P1:  dir_rd = p1_q;
				default: dir_rd = 8'h00;
			endcase
		end
	end

	// Stores move A and the source select only names the location
	always_comb
	begin
		if (dst_sel_i == DST_REG || dst_sel_i == DST_DIR)
			src_val_o = acc_q;
		else
		begin
			case (src_sel_i)
				SRC_REG: src_val_o = iram_q[reg_addr];
				SRC_DIR: src_val_o = dir_rd;
				default: src_val_o = operand_i;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Write side with one write per commit
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			acc_q <= 8'h00;
			psw_q <= 8'h00;
			p1_q  <= 8'h00;
			for (int i = 0; i < IRAM_DEPTH; i++)
				iram_q[i[6:0]] <= 8'h00;
		end
		else if (commit_i)
		begin
			case (dst_sel_i)
				DST_ACC: acc_q <= result_i;
				DST_REG: iram_q[reg_addr] <= result_i;
				DST_DIR:
				begin
					if (!operand_i[7])
						iram_q[operand_i[6:0]] <= result_i;
					else if (operand_i == SFR_ACC)
						acc_q <= result_i;
					else if (operand_i == SFR_PSW)
						psw_q <= result_i;
					else if (operand_i == SFR_P1)
						p1_q <= result_i;
				end
				default: acc_q <= acc_q;
			endcase

			// Arithmetic flags only from ADD and ADDC
			if (alu_op_i == ALU_ADD || alu_op_i == ALU_ADDC)
			begin
				psw_q[PSW_CY] <= cy_i;
				psw_q[PSW_AC] <= ac_i;
				psw_q[PSW_OV] <= ov_i;
			end
		end
	end

	// Write strobe from the sequencer is a single-cycle pulse
	a_commit_pulse : assert property (@(posedge clk) disable iff (!sys_rst_n)
		commit_i |=> !commit_i);

endmodule

`default_nettype wire

//--- hdl/mcs51_decoder.sv
// Opcode decoder producing operand source, ALU operation, destination and branch kind
`default_nettype none

module mcs51_decoder (
	input  logic               clk,
	input  logic               sys_rst_n,
	input  mcs51_pkg::byte_t   opcode_i,
	output logic               has_operand_o,
	output mcs51_pkg::src_e    src_sel_o,
	output mcs51_pkg::dst_e    dst_sel_o,
	output mcs51_pkg::alu_op_e alu_op_o,
	output mcs51_pkg::branch_e branch_kind_o,
	output logic [2:0]         reg_idx_o
);
	import mcs51_pkg::*;

	assign reg_idx_o = opcode_i[2:0];

	always_comb
	begin
		// Anything not listed below behaves as NOP
		has_operand_o = 1'b0;
		src_sel_o     = SRC_IMM;
		dst_sel_o     = DST_NONE;
		alu_op_o      = ALU_PASS;
		branch_kind_o = BR_NONE;

		case (opcode_e'(opcode_i))
			OP_MOV_A_IMM, OP_ADD_IMM, OP_ADDC_IMM, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM:
			begin
				has_operand_o = 1'b1;
				dst_sel_o     = DST_ACC;
			end
			OP_MOV_A_DIR:
			begin
				has_operand_o = 1'b1;
				src_sel_o     = SRC_DIR;
				dst_sel_o     = DST_ACC;
			end
			OP_MOV_DIR_A:
			begin
				has_operand_o = 1'b1;
				src_sel_o     = SRC_DIR;
				dst_sel_o     = DST_DIR;
			end
			OP_CPL_A, OP_RL_A, OP_RR_A, OP_SWAP_A:
				dst_sel_o = DST_ACC;
			OP_SJMP, OP_JZ, OP_JNZ:
				has_operand_o = 1'b1;
			default:
				has_operand_o = 1'b0;
		endcase

		// ALU function of the fixed opcodes
		case (opcode_e'(opcode_i))
			OP_ADD_IMM:  alu_op_o = ALU_ADD;
			OP_ADDC_IMM: alu_op_o = ALU_ADDC;
			OP_ANL_IMM:  alu_op_o = ALU_AND;
			OP_ORL_IMM:  alu_op_o = ALU_OR;
			OP_XRL_IMM:  alu_op_o = ALU_XOR;
			OP_CPL_A:    alu_op_o = ALU_CPL;
			OP_RL_A:     alu_op_o = ALU_RL;
			OP_RR_A:     alu_op_o = ALU_RR;
			OP_SWAP_A:   alu_op_o = ALU_SWAP;
			OP_SJMP:     branch_kind_o = BR_SJMP;
			OP_JZ:       branch_kind_o = BR_JZ;
			OP_JNZ:      branch_kind_o = BR_JNZ;
			default:     alu_op_o = ALU_PASS;
		endcase

		// Rn forms, bit 3 is always set here
		if (opcode_i[3])
		begin
			case (opcode_i[7:3])
				OPH_MOV_A_RN:
				begin
					src_sel_o = SRC_REG;
					dst_sel_o = DST_ACC;
				end
				OPH_MOV_RN_A:
				begin
					src_sel_o = SRC_REG;
					dst_sel_o = DST_REG;
				end
				OPH_ADD_RN, OPH_ADDC_RN:
				begin
					src_sel_o = SRC_REG;
					dst_sel_o = DST_ACC;
					alu_op_o  = (opcode_i[7:3] == OPH_ADD_RN) ? ALU_ADD : ALU_ADDC;
				end
				default:
					dst_sel_o = DST_NONE;
			endcase
		end
	end

	// Register forms never reach the direct address space
	a_reg_not_dir : assert property (@(posedge clk) disable iff (!sys_rst_n)
		opcode_i[3] |-> (dst_sel_o != DST_DIR && src_sel_o != SRC_DIR && !has_operand_o));

endmodule

`default_nettype wire

//--- hdl/mcs51_alu.sv
// Eight-bit ALU with carry, auxiliary carry and overflow generation
`default_nettype none

module mcs51_alu (
	input  mcs51_pkg::alu_op_e op_i,
	input  mcs51_pkg::byte_t   a_i,
	input  mcs51_pkg::byte_t   b_i,
	input  logic               cy_i,
	output mcs51_pkg::byte_t   result_o,
	output logic               cy_o,
	output logic               ac_o,
	output logic               ov_o
);
	import mcs51_pkg::*;

	logic       cin;
	logic [4:0] lo_sum;
	logic [3:0] mid_sum;
	logic [1:0] hi_sum;
	byte_t      sum;

	// Adder split at bit 4 and bit 7 for AC and OV
	assign cin     = (op_i == ALU_ADDC) ? cy_i : 1'b0;
	assign lo_sum  = {1'b0, a_i[3:0]} + {1'b0, b_i[3:0]} + {4'b0, cin};
	assign mid_sum = {1'b0, a_i[6:4]} + {1'b0, b_i[6:4]} + {3'b0, lo_sum[4]};
	assign hi_sum  = {1'b0, a_i[7]} + {1'b0, b_i[7]} + {1'b0, mid_sum[3]};
	assign sum     = {hi_sum[0], mid_sum[2:0], lo_sum[3:0]};

	always_comb
	begin
		cy_o = cy_i;
		ac_o = 1'b0;
		ov_o = 1'b0;
		case (op_i)
			ALU_ADD, ALU_ADDC:
			begin
				result_o = sum;
				cy_o     = hi_sum[1];
				ac_o     = lo_sum[4];
				ov_o     = hi_sum[1] ^ mid_sum[3];
			end
			ALU_AND:  result_o = a_i & b_i;
			ALU_OR:   result_o = a_i | b_i;
			ALU_XOR:  result_o = a_i ^ b_i;
			ALU_CPL:  result_o = ~a_i;
			ALU_RL:   result_o = {a_i[6:0], a_i[7]};
			ALU_RR:   result_o = {a_i[0], a_i[7:1]};
			ALU_SWAP: result_o = {a_i[3:0], a_i[7:4]};
			default:  result_o = b_i;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/mcs51_pkg.sv
// 8051 subset core package with data types, SFR map and control encodings
`default_nettype none

package mcs51_pkg;

	// ------------------------------------------------------------------
	// Basic data types
	// ------------------------------------------------------------------
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;

	// Direct addresses of the SFRs that remain
	localparam byte_t SFR_ACC = 8'hE0;
	localparam byte_t SFR_PSW = 8'hD0;
	localparam byte_t SFR_P1  = 8'h90;

	localparam int IRAM_DEPTH = 128;

	// Bit positions inside PSW
	localparam logic [2:0] PSW_CY  = 3'd7;
	localparam logic [2:0] PSW_AC  = 3'd6;
	localparam logic [2:0] PSW_RS1 = 3'd4;
	localparam logic [2:0] PSW_RS0 = 3'd3;
	localparam logic [2:0] PSW_OV  = 3'd2;
	localparam logic [2:0] PSW_P   = 3'd0;

	// ------------------------------------------------------------------
	// Control encodings
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		PH_FETCH,
		PH_OPERAND,
		PH_EXEC,
		PH_WRITE
	} phase_e;

	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_ADDC,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_CPL,
		ALU_RL,
		ALU_RR,
		ALU_SWAP
	} alu_op_e;

	typedef enum logic [1:0] {SRC_IMM, SRC_REG, SRC_DIR} src_e;

	typedef enum logic [1:0] {DST_NONE, DST_ACC, DST_REG, DST_DIR} dst_e;

	typedef enum logic [1:0] {BR_NONE, BR_SJMP, BR_JZ, BR_JNZ} branch_e;

	// Fixed opcodes of the kept instruction set
	typedef enum logic [7:0] {
		OP_NOP       = 8'h00,
		OP_RR_A      = 8'h03,
		OP_RL_A      = 8'h23,
		OP_ADD_IMM   = 8'h24,
		OP_ADDC_IMM  = 8'h34,
		OP_ORL_IMM   = 8'h44,
		OP_ANL_IMM   = 8'h54,
		OP_JZ        = 8'h60,
		OP_XRL_IMM   = 8'h64,
		OP_JNZ       = 8'h70,
		OP_MOV_A_IMM = 8'h74,
		OP_SJMP      = 8'h80,
		OP_SWAP_A    = 8'hC4,
		OP_MOV_A_DIR = 8'hE5,
		OP_CPL_A     = 8'hF4,
		OP_MOV_DIR_A = 8'hF5
	} opcode_e;

	// Upper five bits of the Rn forms, low three bits pick the register
	localparam logic [4:0] OPH_MOV_A_RN = 5'h1D;
	localparam logic [4:0] OPH_MOV_RN_A = 5'h1F;
	localparam logic [4:0] OPH_ADD_RN   = 5'h05;
	localparam logic [4:0] OPH_ADDC_RN  = 5'h07;

endpackage

`default_nettype wire
